// ==== hdl/mips_alu.sv ====
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::instr_t     instr,
    input  mips_pkg::operands_t  operands,
    output mips_pkg::reg_write_t alu_write,
    output mips_pkg::word_t      eff_addr
);
    import mips_pkg::*;

    word_t imm_sext;
    word_t imm_zext;
    word_t rs_val;
    word_t rt_val;

    assign rs_val   = operands.rs_value;
    assign rt_val   = operands.rt_value;
    assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext = {16'h0000, instr.i.imm};

    // Load/store address
    assign eff_addr = rs_val + imm_sext;

    always_comb begin
        // Default is no write, immediate form destination
        alu_write.enable = 1'b0;
        alu_write.dest   = instr.i.rt;
        alu_write.value  = '0;
        if (instr.r.opcode == OPCODE_R) begin
            alu_write.enable = 1'b1;
            alu_write.dest   = instr.r.rd;
            case (instr.r.funct)
                FUNCT_ADDU: alu_write.value = rs_val + rt_val;
                FUNCT_SUBU: alu_write.value = rs_val - rt_val;
                FUNCT_AND:  alu_write.value = rs_val & rt_val;
                FUNCT_OR:   alu_write.value = rs_val | rt_val;
                FUNCT_XOR:  alu_write.value = rs_val ^ rt_val;
                FUNCT_SLT:  alu_write.value = {31'b0, $signed(rs_val) < $signed(rt_val)};
                FUNCT_SLTU: alu_write.value = {31'b0, rs_val < rt_val};
                // Shifts act on rt by the constant amount
                FUNCT_SLL:  alu_write.value = rt_val << instr.r.shamt;
                FUNCT_SRL:  alu_write.value = rt_val >> instr.r.shamt;
                FUNCT_SRA:  alu_write.value = $signed(rt_val) >>> instr.r.shamt;
                // JR and unknown codes write nothing
                default:    alu_write.enable = 1'b0;
            endcase
        end else begin
            alu_write.enable = 1'b1;
            case (instr.i.opcode)
                OPCODE_ADDIU: alu_write.value = rs_val + imm_sext;
                OPCODE_ANDI:  alu_write.value = rs_val & imm_zext;
                OPCODE_ORI:   alu_write.value = rs_val | imm_zext;
                OPCODE_XORI:  alu_write.value = rs_val ^ imm_zext;
                OPCODE_SLTI:  alu_write.value = {31'b0, $signed(rs_val) < $signed(imm_sext)};
                OPCODE_LUI:   alu_write.value = {instr.i.imm, 16'h0000};
                // Branches, jumps and memory ops are handled elsewhere
                default:      alu_write.enable = 1'b0;
            endcase
        end
    end

endmodule

// ==== hdl/mips_branch_unit.sv ====
`timescale 1ns/1ps

module mips_branch_unit (
    input  mips_pkg::instr_t    instr,
    input  mips_pkg::operands_t operands,
    input  mips_pkg::word_t     pc,
    output mips_pkg::branch_t   branch
);
    import mips_pkg::*;

    word_t pc_next;
    word_t branch_offset;

    // Address of the delay slot
    assign pc_next = pc + INSTR_BYTES;

    // Word offset, sign extended and scaled to bytes
    assign branch_offset = {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};

    always_comb begin
        branch.taken  = 1'b0;
        branch.target = pc_next + branch_offset;
        case (instr.i.opcode)
            OPCODE_BEQ: branch.taken = (operands.rs_value == operands.rt_value);
            OPCODE_BNE: branch.taken = (operands.rs_value != operands.rt_value);
            OPCODE_J: begin
                // Stays inside the current 256 MB region
                branch.taken  = 1'b1;
                branch.target = {pc_next[31:28], instr.i[25:0], 2'b00};
            end
            OPCODE_R: begin
                if (instr.r.funct == FUNCT_JR) begin
                    branch.taken  = 1'b1;
                    branch.target = operands.rs_value;
                end
            end
            default: branch.taken = 1'b0;
        endcase
    end

endmodule

// ==== hdl/mips_controller.sv ====
`timescale 1ns/1ps

module mips_controller (
    input  logic                 clk,
    input  logic                 reset,
    input  mips_pkg::word_t      readdata,
    input  logic                 waitrequest,
    input  mips_pkg::reg_write_t alu_write,
    input  mips_pkg::word_t      eff_addr,
    input  mips_pkg::branch_t    branch,
    input  mips_pkg::word_t      rt_value,
    output mips_pkg::instr_t     instr,
    output mips_pkg::word_t      pc,
    output mips_pkg::reg_write_t wb,
    output logic                 active,
    output logic                 read,
    output logic                 write,
    output mips_pkg::word_t      address,
    output mips_pkg::word_t      writedata,
    output logic [3:0]           byteenable
);
    import mips_pkg::*;

    cpu_state_t state;
    instr_t     ir;
    logic       delay;
    word_t      delay_target;
    logic       is_load;
    logic       is_store;
    logic       fetch_done;
    logic       exec_done;

    // Decode from readdata while fetching so the new word is seen at once
    assign instr = (state == FETCH) ? instr_t'(readdata) : ir;

    assign is_load  = (ir.i.opcode == OPCODE_LW);
    assign is_store = (ir.i.opcode == OPCODE_SW);

    assign fetch_done = (state == FETCH) && (pc != HALT_ADDRESS) && !waitrequest;
    // Memory ops wait on the bus, everything else is a single cycle
    assign exec_done  = (state == EXEC) && !((is_load || is_store) && waitrequest);

    // Bus request, idle while reset is held
    always_comb begin
        read    = 1'b0;
        write   = 1'b0;
        address = pc;
        case (state)
            FETCH: read = (pc != HALT_ADDRESS) && !reset;
            EXEC: begin
                read  = is_load && !reset;
                write = is_store && !reset;
                if (is_load || is_store) begin
                    address = eff_addr;
                end
            end
            default: address = pc;
        endcase
    end

    // Word accesses only
    assign byteenable = (read || write) ? 4'b1111 : 4'b0000;
    assign writedata  = rt_value;

    // Writeback: loaded word for LW, ALU result otherwise, only at the last edge
    always_comb begin
        wb = alu_write;
        if (is_load) begin
            wb.enable = 1'b1;
            wb.dest   = ir.i.rt;
            wb.value  = readdata;
        end
        if (!exec_done) begin
            wb.enable = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= FETCH;
            active <= 1'b1;
            pc     <= RESET_VECTOR;
            delay  <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (pc == HALT_ADDRESS) begin
                        state <= HALTED;
                    end else if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (exec_done) begin
                        state <= FETCH;
                        // Pending jump lands after the delay slot
                        pc    <= delay ? delay_target : pc + INSTR_BYTES;
                        delay <= branch.taken;
                    end
                end
                default: active <= 1'b0;
            endcase
        end
    end

    // Instruction and jump target registers
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            ir <= instr_t'(readdata);
        end
        if (exec_done && branch.taken) begin
            delay_target <= branch.target;
        end
    end

    a_no_read_and_write: assert property (@(posedge clk) !(read && write));

    // No branch or jump inside a delay slot
    a_no_branch_in_slot: assert property (
        @(posedge clk) disable iff (reset)
        (exec_done && delay) |-> !branch.taken
    );

    // Request held unchanged while the slave stalls
    a_bus_stable: assert property (
        @(posedge clk) disable iff (reset)
        ((read || write) && waitrequest) |=>
            $stable({read, write, address, byteenable}) && (!write || $stable(writedata))
    );

endmodule

// ==== hdl/mips_cpu_bus.sv ====
`timescale 1ns/1ps

module mips_cpu_bus (
    input  logic            clk,
    input  logic            reset,
    output logic            active,
    output mips_pkg::word_t register_v0,
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    input  logic            waitrequest,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    input  mips_pkg::word_t readdata
);
    import mips_pkg::*;

    instr_t     instr;
    operands_t  operands;
    reg_write_t alu_write;
    reg_write_t wb;
    branch_t    branch;
    word_t      pc;
    word_t      eff_addr;

    // Register numbers come straight from the current instruction
    mips_regfile i_mips_regfile (
        .clk         (clk),
        .reset       (reset),
        .rs_addr     (instr.i.rs),
        .rt_addr     (instr.i.rt),
        .wb          (wb),
        .operands    (operands),
        .register_v0 (register_v0)
    );

    mips_alu i_mips_alu (
        .instr     (instr),
        .operands  (operands),
        .alu_write (alu_write),
        .eff_addr  (eff_addr)
    );

    mips_branch_unit i_mips_branch_unit (
        .instr    (instr),
        .operands (operands),
        .pc       (pc),
        .branch   (branch)
    );

    mips_controller i_mips_controller (
        .clk         (clk),
        .reset       (reset),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .alu_write   (alu_write),
        .eff_addr    (eff_addr),
        .branch      (branch),
        .rt_value    (operands.rt_value),
        .instr       (instr),
        .pc          (pc),
        .wb          (wb),
        .active      (active),
        .read        (read),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .byteenable  (byteenable)
    );

endmodule

// ==== hdl/mips_pkg.sv ====
package mips_pkg;

    // Basic data and register index types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Primary opcodes handled by this core
    typedef enum logic [5:0] {
        OPCODE_R     = 6'h00,
        OPCODE_J     = 6'h02,
        OPCODE_BEQ   = 6'h04,
        OPCODE_BNE   = 6'h05,
        OPCODE_ADDIU = 6'h09,
        OPCODE_SLTI  = 6'h0a,
        OPCODE_ANDI  = 6'h0c,
        OPCODE_ORI   = 6'h0d,
        OPCODE_XORI  = 6'h0e,
        OPCODE_LUI   = 6'h0f,
        OPCODE_LW    = 6'h23,
        OPCODE_SW    = 6'h2b
    } opcode_t;

    // Function field for register type, JR included
    typedef enum logic [5:0] {
        FUNCT_SLL  = 6'h00,
        FUNCT_SRL  = 6'h02,
        FUNCT_SRA  = 6'h03,
        FUNCT_JR   = 6'h08,
        FUNCT_ADDU = 6'h21,
        FUNCT_SUBU = 6'h23,
        FUNCT_AND  = 6'h24,
        FUNCT_OR   = 6'h25,
        FUNCT_XOR  = 6'h26,
        FUNCT_SLT  = 6'h2a,
        FUNCT_SLTU = 6'h2b
    } funct_t;

    // Register type layout
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_t    funct;
    } r_fields_t;

    // Immediate type layout, low 26 bits double as the jump index
    typedef struct packed {
        opcode_t     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    // One instruction word, two decodings
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    // Register file read ports
    typedef struct packed {
        word_t rs_value;
        word_t rt_value;
    } operands_t;

    // Register file write request
    typedef struct packed {
        logic      enable;
        reg_addr_t dest;
        word_t     value;
    } reg_write_t;

    // Branch decision and destination
    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        HALTED
    } cpu_state_t;

    localparam word_t     RESET_VECTOR = 32'hBFC00000;
    localparam word_t     HALT_ADDRESS = 32'h00000000;
    localparam reg_addr_t REG_V0       = 5'd2;
    localparam word_t     INSTR_BYTES  = 32'd4;

endpackage

// ==== hdl/mips_regfile.sv ====
`timescale 1ns/1ps

module mips_regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  mips_pkg::reg_addr_t  rs_addr,
    input  mips_pkg::reg_addr_t  rt_addr,
    input  mips_pkg::reg_write_t wb,
    output mips_pkg::operands_t  operands,
    output mips_pkg::word_t      register_v0
);
    import mips_pkg::*;

    // General purpose registers, index 0 never written
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.enable && wb.dest != '0) begin
            regs[wb.dest] <= wb.value;
        end
    end

    // Asynchronous read ports
    assign operands.rs_value = regs[rs_addr];
    assign operands.rt_value = regs[rt_addr];

    // Function return register brought out for observation
    assign register_v0 = regs[REG_V0];

    // A write aimed at $zero leaves it at zero on the next cycle
    a_zero_reg_fixed: assert property (
        @(posedge clk) disable iff (reset)
        (wb.enable && wb.dest == '0) |=> (regs[0] == '0)
    );

endmodule

// ==== mips_cpu_bus.f ====
hdl/mips_pkg.sv
hdl/mips_regfile.sv
hdl/mips_alu.sv
hdl/mips_branch_unit.sv
hdl/mips_controller.sv
hdl/mips_cpu_bus.sv
test/tb_mips_memory.sv
test/tb_mips_cpu_bus.sv

// ==== test/tb_mips_cpu_bus.sv ====
`timescale 1ns/1ps

module tb_mips_cpu_bus;
    import mips_pkg::*;

    localparam int    CLK_PERIOD   = 20;
    localparam int    DRIVE_DELAY  = 1;
    localparam int    RESET_CYCLES = 10;
    localparam int    PROG_LEN     = 31;
    localparam word_t DATA_ADDR    = 32'hBFC00100;
    localparam word_t SKIPPED_ADDR = 32'hBFC00070;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       active;
    logic       read;
    logic       write;
    logic       waitrequest;
    logic [3:0] byteenable;
    word_t      register_v0;
    word_t      address;
    word_t      writedata;
    word_t      readdata;

    // Reference model results
    word_t v0_trace [$];
    word_t model_v0 = '0;
    word_t model_store;
    word_t final_v0;
    word_t expected_v0;
    int    expected_fetches;
    int    fetch_count = 0;
    int    errors = 0;
    logic  fetch_seen;
    logic  store_seen;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mips_cpu_bus i_mips_cpu_bus (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    tb_mips_memory i_tb_mips_memory (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    // Completed instruction fetch and completed store
    assign fetch_seen = read && !waitrequest && (address != DATA_ADDR);
    assign store_seen = write && !waitrequest;

    // One executed instruction, v0 value after it
    task automatic retire(input word_t value);
        model_v0 = value;
        v0_trace.push_back(value);
    endtask

    initial begin : isa_model
        word_t t0;
        word_t t1;
        word_t t2;
        word_t t3;
        v0_trace.push_back(model_v0);
        t0 = 32'h8765_0000;
        retire(model_v0);
        t0 = t0 | 32'h0000_4321;
        retire(model_v0);
        t1 = 32'hffff_fffa;
        retire(model_v0);
        retire(t0 + t1);
        retire(model_v0 - t1);
        retire(model_v0 ^ t1);
        retire(model_v0 & t1);
        retire(model_v0 | t0);
        retire(model_v0 << 3);
        retire($signed(model_v0) >>> 2);
        retire(model_v0 >> 1);
        t2 = ($signed(t1) < $signed(model_v0)) ? 32'd1 : 32'd0;
        retire(model_v0);
        retire(model_v0 + t2);
        t2 = (model_v0 < t1) ? 32'd1 : 32'd0;
        retire(model_v0);
        retire(model_v0 + t2);
        // Immediates: addiu sign extends, logic ops zero extend
        retire(model_v0 + 32'hffff_8010);
        retire(model_v0 & 32'h0000_ff0f);
        retire(model_v0 | 32'h0000_8001);
        retire(model_v0 ^ 32'h0000_f00f);
        t2 = ($signed(t1) < -5) ? 32'd1 : 32'd0;
        retire(model_v0);
        retire(model_v0 + t2);
        t0 = 32'hbfc0_0000;
        retire(model_v0);
        model_store = model_v0;
        retire(model_v0);
        retire(32'h0000_0055);
        t3 = model_store;
        retire(model_v0);
        retire(t3);
        // Branch taken since v0 equals t3, slot runs, word 28 skipped
        retire(model_v0);
        retire(model_v0 + 32'h10);
        retire(model_v0);
        retire(model_v0 + 32'd1);
        expected_v0      = v0_trace[0];
        final_v0         = model_v0;
        expected_fetches = v0_trace.size() - 1;
    end

    // Step to the next expected v0 after each fetch
    always @(posedge clk) begin
        if (!reset && fetch_seen) begin
            fetch_count <= fetch_count + 1;
            expected_v0 <= v0_trace[fetch_count + 1];
        end
    end

    a_first_fetch: assert property (@(posedge clk) $fell(reset) |->
        (read && !write && address == RESET_VECTOR && byteenable == 4'hf && active))
        else begin
            errors++;
            $display("First bus access after reset is not a word read at the reset vector");
        end

    a_v0_at_fetch: assert property (@(posedge clk) disable iff (reset)
        fetch_seen |-> register_v0 == expected_v0)
        else begin
            errors++;
            $display("FAIL %0t register_v0 expected %h actual %h", $time,
                     $sampled(expected_v0), $sampled(register_v0));
        end

    a_store_addr: assert property (@(posedge clk) disable iff (reset)
        store_seen |-> address == DATA_ADDR)
        else begin
            errors++;
            $display("FAIL %0t address expected %h actual %h", $time, DATA_ADDR,
                     $sampled(address));
        end

    a_store_data: assert property (@(posedge clk) disable iff (reset)
        store_seen |-> writedata == model_store)
        else begin
            errors++;
            $display("FAIL %0t writedata expected %h actual %h", $time, model_store,
                     $sampled(writedata));
        end

    a_all_lanes: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> byteenable == 4'hf)
        else begin
            errors++;
            $display("FAIL %0t byteenable expected f actual %h", $time, $sampled(byteenable));
        end

    a_skipped: assert property (@(posedge clk) disable iff (reset)
        fetch_seen |-> address != SKIPPED_ADDR)
        else begin
            errors++;
            $display("The instruction after the branch delay slot was fetched");
        end

    a_halt_v0: assert property (@(posedge clk) disable iff (reset)
        $fell(active) |-> register_v0 == final_v0)
        else begin
            errors++;
            $display("FAIL %0t register_v0 expected %h actual %h", $time, final_v0,
                     $sampled(register_v0));
        end

    a_halt_count: assert property (@(posedge clk) disable iff (reset)
        $fell(active) |-> fetch_count == expected_fetches)
        else begin
            errors++;
            $display("Core halted after %0d fetches instead of %0d", $sampled(fetch_count),
                     expected_fetches);
        end

    a_idle_halted: assert property (@(posedge clk) disable iff (reset)
        !active |-> (!read && !write))
        else begin
            errors++;
            $display("Bus request seen after the core halted");
        end

    a_exclusive: assert property (@(posedge clk) !(read && write))
        else begin
            errors++;
            $display("Read and write were high together");
        end

    initial begin : run
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
        wait (active === 1'b0);
        // Keep watching the idle bus for a while after the halt
        repeat (20) @(posedge clk);
        $display("Finished with %0d fetches checked and %0d errors", fetch_count, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Sixteen cycles per instruction is well above the worst stall pattern
    initial begin : watchdog
        #((RESET_CYCLES + PROG_LEN * 16) * CLK_PERIOD);
        $display("Timeout after %0d fetches with %0d errors, core never halted",
                 fetch_count, errors);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== test/tb_mips_memory.sv ====
`timescale 1ns/1ps

module tb_mips_memory (
    input  logic            clk,
    input  logic            reset,
    input  mips_pkg::word_t address,
    input  logic            read,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    input  logic [3:0]      byteenable,
    output logic            waitrequest,
    output mips_pkg::word_t readdata
);
    import mips_pkg::*;

    // Register numbers used by the program
    localparam logic [4:0] ZERO = 5'd0;
    localparam logic [4:0] V0   = 5'd2;
    localparam logic [4:0] T0   = 5'd8;
    localparam logic [4:0] T1   = 5'd9;
    localparam logic [4:0] T2   = 5'd10;
    localparam logic [4:0] T3   = 5'd11;
    localparam int         WORDS = 128;

    // 512 byte window starting at the reset vector
    word_t mem [WORDS];

    // Unwritten words reflect their full address
    function automatic word_t fill_word(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic in_window(input word_t addr);
        return addr[31:9] == RESET_VECTOR[31:9];
    endfunction

    function automatic word_t encode_r(input logic [5:0] funct, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [4:0] rd,
                                       input logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic word_t encode_i(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    initial begin : load_program
        for (int w = 0; w < WORDS; w++) begin
            mem[w] = fill_word(RESET_VECTOR + 4 * w);
        end
        mem[0]  = encode_i(6'h0f, ZERO, T0, 16'h8765);   // lui   t0, 0x8765
        mem[1]  = encode_i(6'h0d, T0, T0, 16'h4321);     // ori   t0, t0, 0x4321
        mem[2]  = encode_i(6'h09, ZERO, T1, 16'hfffa);   // addiu t1, zero, -6
        mem[3]  = encode_r(6'h21, T0, T1, V0, 5'd0);     // addu  v0, t0, t1
        mem[4]  = encode_r(6'h23, V0, T1, V0, 5'd0);     // subu  v0, v0, t1
        mem[5]  = encode_r(6'h26, V0, T1, V0, 5'd0);     // xor   v0, v0, t1
        mem[6]  = encode_r(6'h24, V0, T1, V0, 5'd0);     // and   v0, v0, t1
        mem[7]  = encode_r(6'h25, V0, T0, V0, 5'd0);     // or    v0, v0, t0
        mem[8]  = encode_r(6'h00, ZERO, V0, V0, 5'd3);   // sll   v0, v0, 3
        mem[9]  = encode_r(6'h03, ZERO, V0, V0, 5'd2);   // sra   v0, v0, 2
        mem[10] = encode_r(6'h02, ZERO, V0, V0, 5'd1);   // srl   v0, v0, 1
        mem[11] = encode_r(6'h2a, T1, V0, T2, 5'd0);     // slt   t2, t1, v0
        mem[12] = encode_r(6'h21, V0, T2, V0, 5'd0);     // addu  v0, v0, t2
        mem[13] = encode_r(6'h2b, V0, T1, T2, 5'd0);     // sltu  t2, v0, t1
        mem[14] = encode_r(6'h21, V0, T2, V0, 5'd0);     // addu  v0, v0, t2
        mem[15] = encode_i(6'h09, V0, V0, 16'h8010);     // addiu v0, v0, -32752
        mem[16] = encode_i(6'h0c, V0, V0, 16'hff0f);     // andi  v0, v0, 0xff0f
        mem[17] = encode_i(6'h0d, V0, V0, 16'h8001);     // ori   v0, v0, 0x8001
        mem[18] = encode_i(6'h0e, V0, V0, 16'hf00f);     // xori  v0, v0, 0xf00f
        mem[19] = encode_i(6'h0a, T1, T2, 16'hfffb);     // slti  t2, t1, -5
        mem[20] = encode_r(6'h21, V0, T2, V0, 5'd0);     // addu  v0, v0, t2
        mem[21] = encode_i(6'h0f, ZERO, T0, 16'hbfc0);   // lui   t0, 0xbfc0
        mem[22] = encode_i(6'h2b, T0, V0, 16'h0100);     // sw    v0, 0x100(t0)
        mem[23] = encode_i(6'h09, ZERO, V0, 16'h0055);   // addiu v0, zero, 0x55
        mem[24] = encode_i(6'h23, T0, T3, 16'h0100);     // lw    t3, 0x100(t0)
        mem[25] = encode_r(6'h21, T3, ZERO, V0, 5'd0);   // addu  v0, t3, zero
        mem[26] = encode_i(6'h04, V0, T3, 16'h0002);     // beq   v0, t3, +2
        mem[27] = encode_i(6'h09, V0, V0, 16'h0010);     // addiu v0, v0, 0x10 in the slot
        mem[28] = encode_i(6'h09, ZERO, V0, 16'h0bad);   // skipped by the branch
        mem[29] = encode_r(6'h08, ZERO, ZERO, ZERO, 5'd0); // jr zero
        mem[30] = encode_i(6'h09, V0, V0, 16'h0001);     // addiu v0, v0, 1 in the slot
    end

    // Slave side of the bus with all random draws in this one process
    initial begin : bus_responder
        int unsigned wait_left;
        logic        busy;
        logic        in_reset;
        void'($urandom(32'h9a3d));
        waitrequest = 1'b0;
        readdata    = '0;
        busy        = 1'b0;
        wait_left   = 0;
        forever begin
            @(posedge clk);
            // Reset as seen at the edge, before it can change again
            in_reset = reset;
            // Request finishes at the edge that sees waitrequest low
            if ((read || write) && !waitrequest) begin
                busy = 1'b0;
                if (write && in_window(address)) begin
                    for (int b = 0; b < 4; b++) begin
                        if (byteenable[b]) begin
                            mem[address[8:2]][8*b +: 8] = writedata[8*b +: 8];
                        end
                    end
                end
            end
            #1;
            readdata = in_window(address) ? mem[address[8:2]] : fill_word(address);
            if (in_reset || !(read || write)) begin
                busy        = 1'b0;
                waitrequest = 1'b0;
            end else begin
                // New request gets zero to three stall cycles
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = $urandom % 4;
                end
                waitrequest = (wait_left != 0);
                if (wait_left != 0) begin
                    wait_left--;
                end
            end
        end
    end

endmodule
